/* vlog.f */
common/mem_stage_pkg.sv
design/lane_steer/byte_lane.sv
design/lane_steer/load_assemble.sv
design/mem_access_decode.sv
design/mem_access_ctrl.sv
design/mem_stage_top.sv
dv/mem_stage_properties.sv
dv/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  # shared package
  - common/mem_stage_pkg.sv
  # lane steering
  - design/lane_steer/byte_lane.sv
  - design/lane_steer/load_assemble.sv
  # stage control and top level
  - design/mem_access_decode.sv
  - design/mem_access_ctrl.sv
  - design/mem_stage_top.sv
  # verification
  - target: simulation
    files:
      - dv/mem_stage_properties.sv
      - dv/tb_mem_stage.sv

/* dv/tb_mem_stage.sv */
// testbench for the data-memory stage, runs directed and random operations against a memory model
`timescale 1ns/1ps

module tb_mem_stage;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_OPS      = 78;
  // acceptance, longest memory delay, response edge and writeback
  localparam int OP_CYCLES    = 12;
  localparam mem_stage_pkg::word_t BASE = 32'h0000_1000;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      op_valid_i;
  logic                      op_ready_o;
  mem_stage_pkg::lsu_op_e    op_i;
  mem_stage_pkg::word_t      alu_result_i;
  mem_stage_pkg::word_t      store_data_i;
  mem_stage_pkg::reg_addr_t  wd_i;
  logic                      wreg_i;
  logic                      mem_ce_o;
  logic                      mem_we_o;
  mem_stage_pkg::word_t      mem_addr_o;
  mem_stage_pkg::sel_t       mem_sel_o;
  mem_stage_pkg::word_t      mem_wdata_o;
  mem_stage_pkg::word_t      mem_rdata_i;
  logic                      mem_rdata_valid_i;
  logic                      mem_write_ready_i;
  logic                      wb_valid_o;
  logic                      wb_wreg_o;
  mem_stage_pkg::reg_addr_t  wb_wd_o;
  mem_stage_pkg::word_t      wb_wdata_o;
  mem_stage_pkg::word_t      excepttype_o;

  mem_stage_pkg::word_t mem [64];
  mem_stage_pkg::word_t ref_mem [64];

  int seed         = 4052;
  int err_count    = 0;
  int op_count     = 0;
  int wb_count     = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int test_err0    = 0;
  int test_op0     = 0;

  mem_stage_top dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // counts writeback pulses independently of the operation tasks
  always @(negedge clk_i)
  begin
    if (arst_n_i && wb_valid_o)
    begin
      wb_count++;
    end
  end

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      err_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int access_bytes(input mem_stage_pkg::lsu_op_e op);
    case (op)
      mem_stage_pkg::LSU_LB, mem_stage_pkg::LSU_LBU, mem_stage_pkg::LSU_SB: return 1;
      mem_stage_pkg::LSU_LH, mem_stage_pkg::LSU_LHU, mem_stage_pkg::LSU_SH: return 2;
      mem_stage_pkg::LSU_NONE: return 0;
      default: return 4;
    endcase
  endfunction

  task automatic check_reset_values();
    check_word("op_ready_o in reset state", op_ready_o, 1);
    check_word("mem_ce_o in reset state", mem_ce_o, 0);
    check_word("mem_we_o in reset state", mem_we_o, 0);
    check_word("mem_sel_o in reset state", mem_sel_o, 0);
    check_word("wb_valid_o in reset state", wb_valid_o, 0);
    check_word("wb_wreg_o in reset state", wb_wreg_o, 0);
  endtask

  // issues one operation and checks the bus access and the writeback
  task automatic run_op(input mem_stage_pkg::lsu_op_e op, input mem_stage_pkg::word_t addr,
                        input mem_stage_pkg::word_t data, input mem_stage_pkg::reg_addr_t wd);
    int                   n;
    int                   cycles;
    logic                 is_store;
    logic                 fault;
    logic                 wreg;
    logic                 ce_seen;
    logic                 accepted;
    logic [3:0]           exp_sel;
    mem_stage_pkg::word_t exp_wdata;
    mem_stage_pkg::word_t exp_result;
    mem_stage_pkg::word_t exp_exc;
    mem_stage_pkg::word_t shifted;
    n        = access_bytes(op);
    is_store = (op == mem_stage_pkg::LSU_SB) || (op == mem_stage_pkg::LSU_SH)
      || (op == mem_stage_pkg::LSU_SW);
    fault    = (n == 2 && addr[0]) || (n == 4 && addr[1:0] != 2'b00);
    // register write request is random so stores and faults must mask it
    wreg     = 1'($random(seed));
    exp_sel  = 4'((1 << n) - 1) << addr[1:0];
    case (n)
      1: exp_wdata = {4{data[7:0]}};
      2: exp_wdata = {2{data[15:0]}};
      default: exp_wdata = data;
    endcase
    shifted = ref_mem[addr[7:2]] >> (8 * addr[1:0]);
    case (op)
      mem_stage_pkg::LSU_NONE: exp_result = addr;
      mem_stage_pkg::LSU_LB: exp_result = {{24{shifted[7]}}, shifted[7:0]};
      mem_stage_pkg::LSU_LBU: exp_result = {24'h0, shifted[7:0]};
      mem_stage_pkg::LSU_LH: exp_result = {{16{shifted[15]}}, shifted[15:0]};
      mem_stage_pkg::LSU_LHU: exp_result = {16'h0, shifted[15:0]};
      default: exp_result = shifted;
    endcase
    if (!fault)
      exp_exc = mem_stage_pkg::EXC_NONE;
    else if (is_store)
      exp_exc = mem_stage_pkg::EXC_ADES;
    else
      exp_exc = mem_stage_pkg::EXC_ADEL;

    @(posedge clk_i);
    op_valid_i   <= 1'b1;
    op_i         <= op;
    alu_result_i <= addr;
    store_data_i <= data;
    wd_i         <= wd;
    wreg_i       <= wreg;
    cycles = 0;
    do
    begin
      @(negedge clk_i);
      cycles++;
    end
    while (!op_ready_o && cycles < OP_CYCLES);
    accepted = op_ready_o;
    @(posedge clk_i);
    op_valid_i   <= 1'b0;
    alu_result_i <= $random(seed);
    store_data_i <= $random(seed);
    if (!accepted)
    begin
      err_count++;
      $display("operation %s was never accepted by the stage", op.name());
      return;
    end
    op_count++;

    cycles  = 0;
    ce_seen = 1'b0;
    do
    begin
      @(negedge clk_i);
      cycles++;
      if (cycles == 1)
        check_word("mem_ce_o after acceptance", mem_ce_o, n != 0 && !fault);
      if (mem_ce_o)
      begin
        ce_seen = 1'b1;
        check_word("mem_addr_o", mem_addr_o, addr);
        check_word("mem_sel_o", mem_sel_o, exp_sel);
        check_word("mem_we_o", mem_we_o, is_store);
        if (is_store)
          check_word("mem_wdata_o", mem_wdata_o, exp_wdata);
      end
      if (!wb_valid_o)
        check_word("op_ready_o before writeback", op_ready_o, 0);
    end
    while (!wb_valid_o && cycles < 2 * OP_CYCLES);
    if (!wb_valid_o)
    begin
      err_count++;
      $display("operation %s gave no writeback within %0d cycles", op.name(), cycles);
      return;
    end

    if (n == 0 || fault)
      check_word("cycles from acceptance to writeback", cycles, 1);
    check_word("mem_ce_o activity", ce_seen, n != 0 && !fault);
    check_word("op_ready_o at writeback", op_ready_o, 1);
    check_word("excepttype_o", excepttype_o, exp_exc);
    check_word("wb_wreg_o", wb_wreg_o, wreg && !is_store && !fault);
    if (!is_store && !fault)
    begin
      check_word("wb_wdata_o", wb_wdata_o, exp_result);
      check_word("wb_wd_o", wb_wd_o, wd);
    end
    // expected memory image follows every completed store
    if (is_store && !fault)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (exp_sel[b])
          ref_mem[addr[7:2]][8*b +: 8] = exp_wdata[8*b +: 8];
      end
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    for (int i = 0; i < 64; i++)
      check_word($sformatf("memory word %0d", i), mem[i], ref_mem[i]);
    errs = err_count - test_err0;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("test %-10s %0d operations, %0d errors", name, op_count - test_op0, errs);
    test_err0 = err_count;
    test_op0  = op_count;
  endtask

  // data memory with byte-select writes and a random response delay
  initial
  begin : memory_model
    int                   delay;
    mem_stage_pkg::word_t addr;
    mem_stage_pkg::word_t wdata;
    logic [3:0]           sel;
    logic                 we;
    mem_rdata_i       = '0;
    mem_rdata_valid_i = 1'b0;
    mem_write_ready_i = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (mem_ce_o)
      begin
        delay = $unsigned($random(seed)) % 6;
        repeat (delay) @(negedge clk_i);
        addr  = mem_addr_o;
        wdata = mem_wdata_o;
        sel   = mem_sel_o;
        we    = mem_we_o;
        @(posedge clk_i);
        if (we)
          mem_write_ready_i <= 1'b1;
        else
        begin
          mem_rdata_i       <= mem[addr[7:2]];
          mem_rdata_valid_i <= 1'b1;
        end
        // the stage samples the response at this edge
        @(posedge clk_i);
        if (we)
        begin
          for (int b = 0; b < 4; b++)
          begin
            if (sel[b])
              mem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        mem_write_ready_i <= 1'b0;
        mem_rdata_valid_i <= 1'b0;
        mem_rdata_i       <= $random(seed);
      end
    end
  end

  initial
  begin
    #((RESET_CYCLES + NUM_OPS * OP_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial
  begin : main
    mem_stage_pkg::word_t   addrs [8];
    mem_stage_pkg::word_t   a;
    mem_stage_pkg::lsu_op_e op;
    int                     off;
    arst_n_i     = 1'b0;
    op_valid_i   = 1'b0;
    op_i         = mem_stage_pkg::LSU_NONE;
    alu_result_i = '0;
    store_data_i = '0;
    wd_i         = '0;
    wreg_i       = 1'b0;
    // fill from the word index
    for (int i = 0; i < 64; i++)
    begin
      mem[i]     = (i + 1) * 32'h9E37_79B9;
      ref_mem[i] = mem[i];
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    check_reset_values();
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_reset_values();
    end_test("reset");

    for (int i = 0; i < 8; i++)
    begin
      addrs[i] = BASE | (32'($random(seed)) & 32'h0000_00FC);
      run_op(mem_stage_pkg::LSU_SW, addrs[i], $random(seed), '0);
    end
    for (int i = 0; i < 8; i++)
      run_op(mem_stage_pkg::LSU_LW, addrs[i], $random(seed), 5'(i + 1));
    end_test("sw_lw");

    a = BASE | (32'($random(seed)) & 32'h0000_00FC);
    for (int o = 0; o < 4; o++)
    begin
      run_op(mem_stage_pkg::LSU_SB, a + o, $random(seed), '0);
      run_op(mem_stage_pkg::LSU_LB, a + o, $random(seed), 5'(o + 3));
      run_op(mem_stage_pkg::LSU_LBU, a + o, $random(seed), 5'(o + 9));
    end
    for (int o = 0; o < 4; o += 2)
    begin
      run_op(mem_stage_pkg::LSU_SH, a + o, $random(seed), '0);
      run_op(mem_stage_pkg::LSU_LH, a + o, $random(seed), 5'(o + 17));
      run_op(mem_stage_pkg::LSU_LHU, a + o, $random(seed), 5'(o + 25));
    end
    end_test("subword");

    for (int o = 1; o < 4; o++)
    begin
      a = BASE | (32'($random(seed)) & 32'h0000_00FC) | o;
      run_op(mem_stage_pkg::LSU_LW, a, $random(seed), 5'd7);
      run_op(mem_stage_pkg::LSU_SW, a, $random(seed), '0);
      if (o != 2)
      begin
        run_op(mem_stage_pkg::LSU_LH, a, $random(seed), 5'd8);
        run_op(mem_stage_pkg::LSU_LHU, a, $random(seed), 5'd9);
        run_op(mem_stage_pkg::LSU_SH, a, $random(seed), '0);
      end
    end
    end_test("misalign");

    for (int i = 0; i < 8; i++)
      run_op(mem_stage_pkg::LSU_NONE, $random(seed), $random(seed), 5'($random(seed)));
    end_test("alu_pass");

    // mixed traffic under random memory delays
    for (int i = 0; i < 24; i++)
    begin
      op  = mem_stage_pkg::lsu_op_e'($unsigned($random(seed)) % 9);
      off = $unsigned($random(seed)) & 3 & ~(access_bytes(op) - 1);
      a   = BASE | (32'($random(seed)) & 32'h0000_00FC) | off;
      if (op == mem_stage_pkg::LSU_NONE)
        a = $random(seed);
      run_op(op, a, $random(seed), 5'($random(seed)));
    end
    @(negedge clk_i);
    check_word("writeback pulses against accepted operations", wb_count, op_count);
    check_word("bound property failures", dut_i.props_i.fail_count, 0);
    end_test("mixed");

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* dv/mem_stage_properties.sv */
// bus and handshake properties of the data-memory stage, bound into the stage top level
`timescale 1ns/1ps

module mem_stage_properties (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 op_valid_i,
  input logic                 op_ready_o,
  input logic                 mem_ce_o,
  input logic                 mem_we_o,
  input mem_stage_pkg::word_t mem_addr_o,
  input mem_stage_pkg::sel_t  mem_sel_o,
  input mem_stage_pkg::word_t mem_wdata_o,
  input logic                 mem_rdata_valid_i,
  input logic                 mem_write_ready_i,
  input logic                 wb_valid_o
);

  int unsigned fail_count = 0;
  logic        response;

  // response flag that matches the access direction
  assign response = mem_we_o ? mem_write_ready_i : mem_rdata_valid_i;

  we_needs_ce: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_we_o |-> mem_ce_o)
  else
  begin
    fail_count++;
    $error("write enable raised without chip enable");
  end

  bus_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_ce_o && !response |=> mem_ce_o && $stable(mem_we_o) && $stable(mem_addr_o)
      && $stable(mem_sel_o) && $stable(mem_wdata_o))
  else
  begin
    fail_count++;
    $error("bus request changed before the memory answered");
  end

  // a new operation taken in the writeback cycle may legally write back again
  wb_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_o && !op_valid_i |=> !wb_valid_o)
  else
  begin
    fail_count++;
    $error("writeback valid held for more than one cycle");
  end

  busy_not_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_ce_o |-> !op_ready_o)
  else
  begin
    fail_count++;
    $error("stage ready while a bus access is open");
  end

endmodule

bind mem_stage_top mem_stage_properties props_i (
  .clk_i             (clk_i),
  .arst_n_i          (arst_n_i),
  .op_valid_i        (op_valid_i),
  .op_ready_o        (op_ready_o),
  .mem_ce_o          (mem_ce_o),
  .mem_we_o          (mem_we_o),
  .mem_addr_o        (mem_addr_o),
  .mem_sel_o         (mem_sel_o),
  .mem_wdata_o       (mem_wdata_o),
  .mem_rdata_valid_i (mem_rdata_valid_i),
  .mem_write_ready_i (mem_write_ready_i),
  .wb_valid_o        (wb_valid_o)
);

/* design/mem_stage_top.sv */
// data-memory stage top level, connects the execute stage, the data bus and writeback
`timescale 1ns/1ps

module mem_stage_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // execute stage
  input  logic                      op_valid_i,
  output logic                      op_ready_o,
  input  mem_stage_pkg::lsu_op_e    op_i,
  input  mem_stage_pkg::word_t      alu_result_i,
  input  mem_stage_pkg::word_t      store_data_i,
  input  mem_stage_pkg::reg_addr_t  wd_i,
  input  logic                      wreg_i,
  // data memory bus
  output logic                      mem_ce_o,
  output logic                      mem_we_o,
  output mem_stage_pkg::word_t      mem_addr_o,
  output mem_stage_pkg::sel_t       mem_sel_o,
  output mem_stage_pkg::word_t      mem_wdata_o,
  input  mem_stage_pkg::word_t      mem_rdata_i,
  input  logic                      mem_rdata_valid_i,
  input  logic                      mem_write_ready_i,
  // writeback
  output logic                      wb_valid_o,
  output logic                      wb_wreg_o,
  output mem_stage_pkg::reg_addr_t  wb_wd_o,
  output mem_stage_pkg::word_t      wb_wdata_o,
  output mem_stage_pkg::word_t      excepttype_o
);

  mem_stage_pkg::lsu_op_e      held_op;
  mem_stage_pkg::word_t        held_addr;
  mem_stage_pkg::word_t        held_store;
  mem_stage_pkg::access_size_e size;
  logic                        is_signed;
  logic                        is_mem;
  logic                        is_store;
  logic                        addr_err;
  mem_stage_pkg::sel_t         lane_sel;
  mem_stage_pkg::word_t        lane_wdata;
  mem_stage_pkg::word_t        load_word;

  mem_stage_pkg::byte_t     [mem_stage_pkg::NUM_LANES-1:0] load_byte;
  mem_stage_pkg::lane_idx_t [mem_stage_pkg::NUM_LANES-1:0] load_pos;

  mem_access_ctrl ctrl_i (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .op_valid_i        (op_valid_i),
    .op_ready_o        (op_ready_o),
    .op_i              (op_i),
    .alu_result_i      (alu_result_i),
    .store_data_i      (store_data_i),
    .wd_i              (wd_i),
    .wreg_i            (wreg_i),
    .held_op_o         (held_op),
    .held_addr_o       (held_addr),
    .held_store_o      (held_store),
    .addr_err_i        (addr_err),
    .is_mem_i          (is_mem),
    .is_store_i        (is_store),
    .lane_sel_i        (lane_sel),
    .lane_wdata_i      (lane_wdata),
    .load_word_i       (load_word),
    .mem_ce_o          (mem_ce_o),
    .mem_we_o          (mem_we_o),
    .mem_addr_o        (mem_addr_o),
    .mem_sel_o         (mem_sel_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_rdata_valid_i (mem_rdata_valid_i),
    .mem_write_ready_i (mem_write_ready_i),
    .wb_valid_o        (wb_valid_o),
    .wb_wreg_o         (wb_wreg_o),
    .wb_wd_o           (wb_wd_o),
    .wb_wdata_o        (wb_wdata_o),
    .excepttype_o      (excepttype_o)
  );

  mem_access_decode decode_i (
    .held_op_i   (held_op),
    .held_addr_i (held_addr),
    .size_o      (size),
    .signed_o    (is_signed),
    .is_mem_o    (is_mem),
    .is_store_o  (is_store),
    .addr_err_o  (addr_err)
  );

  // one lane per byte of the bus word
  for (genvar g = 0; g < mem_stage_pkg::NUM_LANES; g++)
  begin : gen_lane
    byte_lane #(
      .LANE (g)
    ) lane_i (
      .size_i       (size),
      .offset_i     (held_addr[1:0]),
      .store_data_i (held_store),
      .rdata_i      (mem_rdata_i),
      .sel_o        (lane_sel[g]),
      .wbyte_o      (lane_wdata[8*g +: 8]),
      .load_byte_o  (load_byte[g]),
      .load_pos_o   (load_pos[g])
    );
  end

  load_assemble assemble_i (
    .lane_sel_i  (lane_sel),
    .load_byte_i (load_byte),
    .load_pos_i  (load_pos),
    .size_i      (size),
    .signed_i    (is_signed),
    .load_word_o (load_word)
  );

endmodule

/* design/mem_access_ctrl.sv */
// holds the accepted operation, runs the bus access and presents the writeback result
`timescale 1ns/1ps

module mem_access_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      op_valid_i,
  output logic                      op_ready_o,
  input  mem_stage_pkg::lsu_op_e    op_i,
  input  mem_stage_pkg::word_t      alu_result_i,
  input  mem_stage_pkg::word_t      store_data_i,
  input  mem_stage_pkg::reg_addr_t  wd_i,
  input  logic                      wreg_i,
  output mem_stage_pkg::lsu_op_e    held_op_o,
  output mem_stage_pkg::word_t      held_addr_o,
  output mem_stage_pkg::word_t      held_store_o,
  input  logic                      addr_err_i,
  input  logic                      is_mem_i,
  input  logic                      is_store_i,
  input  mem_stage_pkg::sel_t       lane_sel_i,
  input  mem_stage_pkg::word_t      lane_wdata_i,
  input  mem_stage_pkg::word_t      load_word_i,
  output logic                      mem_ce_o,
  output logic                      mem_we_o,
  output mem_stage_pkg::word_t      mem_addr_o,
  output mem_stage_pkg::sel_t       mem_sel_o,
  output mem_stage_pkg::word_t      mem_wdata_o,
  input  logic                      mem_rdata_valid_i,
  input  logic                      mem_write_ready_i,
  output logic                      wb_valid_o,
  output logic                      wb_wreg_o,
  output mem_stage_pkg::reg_addr_t  wb_wd_o,
  output mem_stage_pkg::word_t      wb_wdata_o,
  output mem_stage_pkg::word_t      excepttype_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_WB
  } state_e;

  state_e                    state_q;
  state_e                    state_d;
  logic                      accept;
  logic                      direct_wb;
  logic                      bus_done;
  logic                      held_wreg_q;
  mem_stage_pkg::reg_addr_t  held_wd_q;
  mem_stage_pkg::word_t      wb_wdata_q;

  // non-memory and faulting ops finish in their first cycle, without the bus
  assign direct_wb = (state_q == ST_ACCESS) && (!is_mem_i || addr_err_i);

  assign mem_ce_o    = (state_q == ST_ACCESS) && is_mem_i && !addr_err_i;
  assign mem_we_o    = mem_ce_o && is_store_i;
  assign mem_addr_o  = held_addr_o;
  assign mem_sel_o   = mem_ce_o ? lane_sel_i : '0;
  assign mem_wdata_o = lane_wdata_i;

  // response flag depends on direction
  assign bus_done = mem_ce_o && (is_store_i ? mem_write_ready_i : mem_rdata_valid_i);

  assign wb_valid_o = (state_q == ST_WB) || direct_wb;
  assign op_ready_o = (state_q == ST_IDLE) || wb_valid_o;
  assign accept     = op_valid_i && op_ready_o;

  always_comb
  begin
    if (op_ready_o)
    begin
      state_d = accept ? ST_ACCESS : ST_IDLE;
    end
    else if (bus_done)
    begin
      state_d = ST_WB;
    end
    else
    begin
      state_d = state_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q     <= ST_IDLE;
      held_op_o   <= mem_stage_pkg::LSU_NONE;
      held_wreg_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        held_op_o   <= op_i;
        held_wreg_q <= wreg_i;
      end
    end
  end

  // operand and result payload
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      held_addr_o  <= alu_result_i;
      held_store_o <= store_data_i;
      held_wd_q    <= wd_i;
      wb_wdata_q   <= alu_result_i;
    end
    else if (bus_done && !is_store_i)
    begin
      wb_wdata_q <= load_word_i;
    end
  end

  // stores and faults never write the register file
  assign wb_wreg_o  = wb_valid_o && held_wreg_q && !is_store_i && !addr_err_i;
  assign wb_wd_o    = held_wd_q;
  assign wb_wdata_o = wb_wdata_q;

  always_comb
  begin
    if (!addr_err_i)
    begin
      excepttype_o = mem_stage_pkg::EXC_NONE;
    end
    else if (is_store_i)
    begin
      excepttype_o = mem_stage_pkg::EXC_ADES;
    end
    else
    begin
      excepttype_o = mem_stage_pkg::EXC_ADEL;
    end
  end

endmodule

/* design/mem_access_decode.sv */
// decodes the held operation into access size, signedness, direction and alignment fault
`timescale 1ns/1ps

module mem_access_decode (
  input  mem_stage_pkg::lsu_op_e      held_op_i,
  input  mem_stage_pkg::word_t        held_addr_i,
  output mem_stage_pkg::access_size_e size_o,
  output logic                        signed_o,
  output logic                        is_mem_o,
  output logic                        is_store_o,
  output logic                        addr_err_o
);

  logic misaligned;

  always_comb
  begin
    size_o     = mem_stage_pkg::SIZE_WORD;
    signed_o   = 1'b0;
    is_mem_o   = 1'b1;
    is_store_o = 1'b0;
    case (held_op_i)
      mem_stage_pkg::LSU_LB:
      begin
        size_o   = mem_stage_pkg::SIZE_BYTE;
        signed_o = 1'b1;
      end
      mem_stage_pkg::LSU_LBU:
      begin
        size_o = mem_stage_pkg::SIZE_BYTE;
      end
      mem_stage_pkg::LSU_LH:
      begin
        size_o   = mem_stage_pkg::SIZE_HALF;
        signed_o = 1'b1;
      end
      mem_stage_pkg::LSU_LHU:
      begin
        size_o = mem_stage_pkg::SIZE_HALF;
      end
      mem_stage_pkg::LSU_LW:
      begin
        size_o = mem_stage_pkg::SIZE_WORD;
      end
      mem_stage_pkg::LSU_SB:
      begin
        size_o     = mem_stage_pkg::SIZE_BYTE;
        is_store_o = 1'b1;
      end
      mem_stage_pkg::LSU_SH:
      begin
        size_o     = mem_stage_pkg::SIZE_HALF;
        is_store_o = 1'b1;
      end
      mem_stage_pkg::LSU_SW:
      begin
        is_store_o = 1'b1;
      end
      default:
      begin
        // plain alu result, no bus access
        is_mem_o = 1'b0;
      end
    endcase
  end

  // halfwords on even bytes, words on word boundaries
  always_comb
  begin
    case (size_o)
      mem_stage_pkg::SIZE_HALF:
      begin
        misaligned = held_addr_i[0];
      end
      mem_stage_pkg::SIZE_WORD:
      begin
        misaligned = (held_addr_i[1:0] != 2'b00);
      end
      default:
      begin
        misaligned = 1'b0;
      end
    endcase
  end

  assign addr_err_o = is_mem_o && misaligned;

endmodule

/* design/lane_steer/load_assemble.sv */
// collects the selected lane bytes into the load result and extends it to a full word
`timescale 1ns/1ps

module load_assemble (
  input  mem_stage_pkg::sel_t                                      lane_sel_i,
  input  mem_stage_pkg::byte_t     [mem_stage_pkg::NUM_LANES-1:0] load_byte_i,
  input  mem_stage_pkg::lane_idx_t [mem_stage_pkg::NUM_LANES-1:0] load_pos_i,
  input  mem_stage_pkg::access_size_e                              size_i,
  input  logic                                                     signed_i,
  output mem_stage_pkg::word_t                                     load_word_o
);

  mem_stage_pkg::word_t     placed;
  mem_stage_pkg::lane_idx_t last;
  logic                     fill_bit;

  // move each selected byte to its place in the result
  always_comb
  begin
    placed = '0;
    for (int i = 0; i < mem_stage_pkg::NUM_LANES; i++)
    begin
      if (lane_sel_i[i])
      begin
        placed[8*load_pos_i[i] +: 8] = load_byte_i[i];
      end
    end
  end

  assign last = mem_stage_pkg::size_last(size_i);

  // top bit of the highest loaded byte
  assign fill_bit = signed_i && placed[8*last + 7];

  always_comb
  begin
    for (int j = 0; j < mem_stage_pkg::NUM_LANES; j++)
    begin
      if (j > last)
      begin
        load_word_o[8*j +: 8] = {8{fill_bit}};
      end
      else
      begin
        load_word_o[8*j +: 8] = placed[8*j +: 8];
      end
    end
  end

endmodule

/* design/lane_steer/byte_lane.sv */
// one byte lane of the data bus: byte select, store byte and load byte placement
`timescale 1ns/1ps

module byte_lane #(
  parameter int LANE = 0
) (
  input  mem_stage_pkg::access_size_e size_i,
  input  mem_stage_pkg::lane_idx_t    offset_i,
  input  mem_stage_pkg::word_t        store_data_i,
  input  mem_stage_pkg::word_t        rdata_i,
  output logic                        sel_o,
  output mem_stage_pkg::byte_t        wbyte_o,
  output mem_stage_pkg::byte_t        load_byte_o,
  output mem_stage_pkg::lane_idx_t    load_pos_o
);

  localparam mem_stage_pkg::lane_idx_t LANE_IDX = mem_stage_pkg::lane_idx_t'(LANE);

  mem_stage_pkg::lane_idx_t last;
  mem_stage_pkg::lane_idx_t rel;
  mem_stage_pkg::lane_idx_t src;

  assign last = mem_stage_pkg::size_last(size_i);

  // byte position inside the access, wraps for lanes below the offset
  assign rel = LANE_IDX - offset_i;

  assign sel_o = (LANE_IDX >= offset_i) && (rel <= last);

  // masking by size repeats the low byte or half on every lane
  assign src     = rel & last;
  assign wbyte_o = store_data_i[8*src +: 8];

  // load side
  assign load_byte_o = rdata_i[8*LANE +: 8];
  assign load_pos_o  = rel;

endmodule

/* common/mem_stage_pkg.sv */
// shared widths, types, operation codes and exception codes for the data-memory stage RTL
package mem_stage_pkg;

  localparam int DATA_W     = 32;
  localparam int NUM_LANES  = 4;
  localparam int REG_ADDR_W = 5;

  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [7:0]            byte_t;
  typedef logic [NUM_LANES-1:0]  sel_t;
  typedef logic [1:0]            lane_idx_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // operations handed over by the execute stage
  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,
    LSU_LBU  = 4'd2,
    LSU_LH   = 4'd3,
    LSU_LHU  = 4'd4,
    LSU_LW   = 4'd5,
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  // cause codes as seen by the writeback stage
  localparam word_t EXC_NONE = 32'h0000_0000;
  localparam word_t EXC_ADEL = 32'h0000_0004;
  localparam word_t EXC_ADES = 32'h0000_0005;

  // offset of the last byte of an access, i.e. size in bytes minus one
  function automatic lane_idx_t size_last(access_size_e size);
    lane_idx_t last;
    case (size)
      SIZE_HALF:
      begin
        last = 2'd1;
      end
      SIZE_WORD:
      begin
        last = 2'd3;
      end
      default:
      begin
        last = 2'd0;
      end
    endcase
    return last;
  endfunction

endpackage
